/* rtl/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry
`define DC_WAYS       2
`define DC_SETS       64
`define DC_LINE_WORDS 16

// request and bus widths
`define DC_ADDR_W     32
`define DC_DATA_W     32
`define DC_STRB_W     4

`endif

/* rtl/dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]             addr_t;
    typedef logic [`DC_DATA_W-1:0]             word_t;
    typedef logic [`DC_STRB_W-1:0]             strobe_t;
    typedef logic [$clog2(`DC_SETS)-1:0]       index_t;
    typedef logic [$clog2(`DC_LINE_WORDS)-1:0] offset_t;
    typedef logic [$clog2(`DC_WAYS)-1:0]       way_t;

    // whatever is left above index, offset and byte select
    typedef logic [`DC_ADDR_W-$bits(index_t)-$bits(offset_t)-$clog2(`DC_STRB_W)-1:0] tag_t;

    // way, then index, then word offset
    typedef logic [$bits(way_t)+$bits(index_t)+$bits(offset_t)-1:0] ram_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        WB_READ,
        WRITEBACK,
        FETCH,
        REPLAY
    } ctrl_state_t;

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[`DC_ADDR_W-1 -: $bits(tag_t)];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[$clog2(`DC_STRB_W)+$bits(offset_t) +: $bits(index_t)];
    endfunction

    function automatic offset_t addr_offset(input addr_t addr);
        return addr[$clog2(`DC_STRB_W) +: $bits(offset_t)];
    endfunction

    // first byte of a line
    function automatic addr_t line_addr(input tag_t tag, input index_t index);
        return {tag, index, {($bits(offset_t) + $clog2(`DC_STRB_W)){1'b0}}};
    endfunction

endpackage

/* rtl/dcache_ifs.sv */
interface meta_if
    import dcache_pkg::*;
();
    addr_t lookup_addr;
    logic  accept;

    // result for the registered request
    logic  hit;
    way_t  hit_way;
    way_t  victim_way;
    logic  victim_dirty;
    tag_t  victim_tag;

    logic  touch_en;
    way_t  touch_way;
    logic  touch_write;

    logic  fill_en;
    way_t  fill_way;
    tag_t  fill_tag;
    logic  fill_dirty;

    modport store (
        input  lookup_addr, accept, touch_en, touch_way, touch_write,
        input  fill_en, fill_way, fill_tag, fill_dirty,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport controller (
        output lookup_addr, accept, touch_en, touch_way, touch_write,
        output fill_en, fill_way, fill_tag, fill_dirty,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag
    );
endinterface

interface data_port_if
    import dcache_pkg::*;
();
    logic      en;
    strobe_t   wstrobe;
    ram_addr_t addr;
    word_t     wdata;
    word_t     rdata;

    modport controller (output en, wstrobe, addr, wdata, input rdata);
    modport memory (input en, wstrobe, addr, wdata, output rdata);
endinterface

/* rtl/dcache_tag_store.sv */
`include "dcache_macros.svh"

module dcache_tag_store
    import dcache_pkg::*;
(
    input logic   clk,
    input logic   resetn,
    meta_if.store meta
);
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_q;
    logic [`DC_SETS-1:0]               lru_q;
    tag_t                              tag_q [`DC_WAYS][`DC_SETS];

    index_t              lookup_idx;
    logic [`DC_WAYS-1:0] hit_vec;
    way_t                hit_way_c;

    // lookup result held for the request in the processing stage
    logic   hit_q;
    way_t   hit_way_q;
    index_t stage_idx;
    way_t   victim;

    assign lookup_idx = addr_index(meta.lookup_addr);

    always_comb begin
        hit_way_c = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = valid_q[w][lookup_idx]
                         && tag_q[w][lookup_idx] == addr_tag(meta.lookup_addr);
            if (hit_vec[w]) begin
                hit_way_c = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            hit_q <= 1'b0;
        end else if (meta.accept) begin
            hit_q <= |hit_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (meta.accept) begin
            hit_way_q <= hit_way_c;
            stage_idx <= lookup_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (meta.fill_en) begin
            tag_q[meta.fill_way][stage_idx] <= meta.fill_tag;
        end
    end

    // lru bit points away from the way used last
    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (meta.fill_en) begin
            valid_q[meta.fill_way][stage_idx] <= 1'b1;
            dirty_q[meta.fill_way][stage_idx] <= meta.fill_dirty;
            lru_q[stage_idx]                  <= ~meta.fill_way;
        end else if (meta.touch_en) begin
            lru_q[stage_idx] <= ~meta.touch_way;
            if (meta.touch_write) begin
                dirty_q[meta.touch_way][stage_idx] <= 1'b1;
            end
        end
    end

    assign victim            = way_t'(lru_q[stage_idx]);
    assign meta.hit          = hit_q;
    assign meta.hit_way      = hit_way_q;
    assign meta.victim_way   = victim;
    assign meta.victim_dirty = dirty_q[victim][stage_idx];
    assign meta.victim_tag   = tag_q[victim][stage_idx];

    // a tag lives in at most one way of its set
    a_single_hit: assert property (@(posedge clk) disable iff (resetn)
        meta.accept |-> $onehot0(hit_vec));

endmodule

/* rtl/dcache_data_ram.sv */
`include "dcache_macros.svh"

module dcache_data_ram
    import dcache_pkg::*;
(
    input logic         clk,
    data_port_if.memory port_a,
    data_port_if.memory port_b
);
    word_t mem [2**$bits(ram_addr_t)];

    function automatic word_t merge(input word_t old_word, input word_t new_word,
                                    input strobe_t strobe);
        word_t result;
        result = old_word;
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (strobe[b]) begin
                result[b*(`DC_DATA_W/`DC_STRB_W) +: `DC_DATA_W/`DC_STRB_W] =
                    new_word[b*(`DC_DATA_W/`DC_STRB_W) +: `DC_DATA_W/`DC_STRB_W];
            end
        end
        return result;
    endfunction

    // read returns the word as it was before this edge
    always_ff @(posedge clk) begin
        if (port_a.en) begin
            mem[port_a.addr] <= merge(mem[port_a.addr], port_a.wdata, port_a.wstrobe);
            port_a.rdata     <= mem[port_a.addr];
        end
        if (port_b.en) begin
            mem[port_b.addr] <= merge(mem[port_b.addr], port_b.wdata, port_b.wstrobe);
            port_b.rdata     <= mem[port_b.addr];
        end
    end

    a_no_write_clash: assert property (@(posedge clk)
        port_a.en && port_b.en && |port_a.wstrobe && |port_b.wstrobe
        |-> port_a.addr != port_b.addr);

endmodule

/* rtl/dcache_miss_ctrl.sv */
`include "dcache_macros.svh"

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  logic            clk,
    input  logic            resetn,
    input  logic            req_valid,
    input  addr_t           req_addr,
    input  strobe_t         req_strobe,
    input  word_t           req_wdata,
    output logic            addr_ok,
    output logic            data_ok,
    output word_t           rdata,
    output logic            creq_valid,
    output logic            creq_is_write,
    output addr_t           creq_addr,
    output word_t           creq_wdata,
    input  logic            cresp_ready,
    input  logic            cresp_last,
    input  word_t           cresp_data,
    meta_if.controller      meta,
    data_port_if.controller port_a,
    data_port_if.controller port_b
);
    ctrl_state_t state;

    // processing stage
    logic    stage_valid;
    addr_t   stage_addr;
    strobe_t stage_strobe;
    word_t   stage_wdata;
    index_t  idx;

    logic    hit_serve;
    way_t    miss_way;
    way_t    serve_way;
    offset_t beat;
    logic [$bits(offset_t):0] rd_cnt;
    word_t   line_buf [`DC_LINE_WORDS];

    assign idx       = addr_index(stage_addr);
    assign hit_serve = state == IDLE && stage_valid && meta.hit;
    assign addr_ok   = state == IDLE && !(stage_valid && !meta.hit);
    assign serve_way = (state == REPLAY) ? miss_way : meta.hit_way;

    assign meta.lookup_addr = req_addr;
    assign meta.accept      = addr_ok && req_valid;
    assign meta.touch_en    = hit_serve;
    assign meta.touch_way   = meta.hit_way;
    assign meta.touch_write = |stage_strobe;
    assign meta.fill_en     = state == FETCH && cresp_ready && cresp_last;
    assign meta.fill_way    = miss_way;
    assign meta.fill_tag    = addr_tag(stage_addr);
    assign meta.fill_dirty  = |stage_strobe;

    // port a serves hits and the replayed request
    assign port_a.en      = hit_serve || state == REPLAY;
    assign port_a.wstrobe = stage_strobe;
    assign port_a.addr    = {serve_way, idx, addr_offset(stage_addr)};
    assign port_a.wdata   = stage_wdata;
    assign rdata          = port_a.rdata;

    // port b reads the victim out and takes the fill beats
    assign port_b.en      = (state == WB_READ && !rd_cnt[$bits(offset_t)])
                            || (state == FETCH && cresp_ready);
    assign port_b.wstrobe = {`DC_STRB_W{state == FETCH}};
    assign port_b.addr    = {miss_way, idx, (state == FETCH) ? beat : offset_t'(rd_cnt)};
    assign port_b.wdata   = cresp_data;

    assign creq_valid    = state == WRITEBACK || state == FETCH;
    assign creq_is_write = state == WRITEBACK;
    assign creq_addr     = line_addr(creq_is_write ? meta.victim_tag : addr_tag(stage_addr), idx);
    assign creq_wdata    = line_buf[beat];

    always_ff @(posedge clk) begin
        if (resetn) begin
            stage_valid <= 1'b0;
        end else if (addr_ok || state == REPLAY) begin
            stage_valid <= meta.accept;
        end
    end

    always_ff @(posedge clk) begin
        if (meta.accept) begin
            stage_addr   <= req_addr;
            stage_strobe <= req_strobe;
            stage_wdata  <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= hit_serve || state == REPLAY;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state  <= IDLE;
            rd_cnt <= '0;
            beat   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    rd_cnt <= '0;
                    beat   <= '0;
                    if (stage_valid && !meta.hit) begin
                        state <= meta.victim_dirty ? WB_READ : FETCH;
                    end
                end
                WB_READ: begin
                    // one extra cycle for the last read word
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt[$bits(offset_t)]) begin
                        state <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    if (cresp_ready) begin
                        beat <= beat + 1'b1;
                        if (cresp_last) begin
                            state <= FETCH;
                        end
                    end
                end
                FETCH: begin
                    if (cresp_ready) begin
                        beat <= beat + 1'b1;
                        if (cresp_last) begin
                            state <= REPLAY;
                        end
                    end
                end
                REPLAY: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            miss_way <= meta.victim_way;
        end
        if (state == WB_READ && rd_cnt != '0) begin
            line_buf[offset_t'(rd_cnt - 1'b1)] <= port_b.rdata;
        end
    end

    // no burst follows an open port or the replay
    a_bus_quiet: assert property (@(posedge clk) disable iff (resetn)
        (addr_ok || state == REPLAY) |=> !creq_valid);

    // once stalled, the port stays closed until the replay
    a_stall_outside_idle: assert property (@(posedge clk) disable iff (resetn)
        !addr_ok && state != REPLAY |=> !addr_ok);

    a_burst_hold: assert property (@(posedge clk) disable iff (resetn)
        creq_valid && !cresp_ready
        |=> creq_valid && $stable(creq_addr) && $stable(creq_is_write));

endmodule

/* rtl/dcache_top.sv */
module dcache_top
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    req_valid,
    input  addr_t   req_addr,
    input  strobe_t req_strobe,
    input  word_t   req_wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    output logic    creq_valid,
    output logic    creq_is_write,
    output addr_t   creq_addr,
    output word_t   creq_wdata,
    input  logic    cresp_ready,
    input  logic    cresp_last,
    input  word_t   cresp_data
);
    meta_if      meta ();
    data_port_if port_a ();
    data_port_if port_b ();

    dcache_miss_ctrl u_ctrl (
        .clk           (clk),
        .resetn        (resetn),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_strobe    (req_strobe),
        .req_wdata     (req_wdata),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_wdata    (creq_wdata),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data),
        .meta          (meta),
        .port_a        (port_a),
        .port_b        (port_b)
    );

    dcache_tag_store u_tags (
        .clk    (clk),
        .resetn (resetn),
        .meta   (meta)
    );

    dcache_data_ram u_data (
        .clk    (clk),
        .port_a (port_a),
        .port_b (port_b)
    );

endmodule

/* bench/mem_model.sv */
`include "dcache_macros.svh"

module mem_model
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  creq_valid,
    input  logic  creq_is_write,
    input  addr_t creq_addr,
    input  word_t creq_wdata,
    output logic  cresp_ready,
    output logic  cresp_last,
    output word_t cresp_data
);
    word_t   mem [addr_t];
    offset_t beat;

    // untouched words hold a value made from their word address
    function automatic word_t fill_word(input addr_t a);
        return {a[17:2], a[31:16]} ^ 32'ha5c3_3c5a;
    endfunction

    function automatic word_t read_word(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    initial begin
        cresp_ready = 1'b0;
        cresp_last  = 1'b0;
        cresp_data  = '0;
        beat        = '0;
    end

    always @(posedge clk) begin
        if (resetn) begin
            beat = '0;
        end else if (creq_valid && cresp_ready) begin
            if (creq_is_write) begin
                mem[creq_addr + addr_t'({beat, 2'b00})] = creq_wdata;
            end
            // wraps to zero after the last beat
            beat = beat + 1'b1;
        end
        #1;
        // ready is low about one beat in four
        cresp_ready = !resetn && ($urandom % 4 != 0);
        cresp_last  = beat == offset_t'(`DC_LINE_WORDS - 1);
        cresp_data  = read_word(creq_addr + addr_t'({beat, 2'b00}));
    end

endmodule

/* bench/tb_dcache.sv */
`include "dcache_macros.svh"

module tb_dcache
    import dcache_pkg::*;
();
    localparam int reset_cycles = 10;
    localparam int max_cycles   = 4000;

    logic    clk;
    logic    resetn;
    logic    req_valid;
    addr_t   req_addr;
    strobe_t req_strobe;
    word_t   req_wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    creq_valid;
    logic    creq_is_write;
    addr_t   creq_addr;
    word_t   creq_wdata;
    logic    cresp_ready;
    logic    cresp_last;
    word_t   cresp_data;

    int cycle = 0;

    // expected responses, oldest first
    logic  exp_read [$];
    word_t exp_data [$];
    word_t shadow [addr_t];
    logic  head_valid;
    logic  head_read;
    word_t head_data;
    int    outstanding;

    logic    in_burst;
    addr_t   burst_addr;
    logic    burst_write;
    offset_t burst_beat;
    int      fetch_count;
    int      wb_count;
    addr_t   wb_addr;

    dcache_top u_dut (
        .clk           (clk),
        .resetn        (resetn),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_strobe    (req_strobe),
        .req_wdata     (req_wdata),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_wdata    (creq_wdata),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

    mem_model u_mem (
        .clk           (clk),
        .resetn        (resetn),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_wdata    (creq_wdata),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic word_t fill_word(input addr_t a);
        return {a[17:2], a[31:16]} ^ 32'ha5c3_3c5a;
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return fill_word(a);
    endfunction

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                         input strobe_t strobe);
        word_t result;
        result = old_word;
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (strobe[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic addr_t compose_addr(input tag_t tag, input index_t idx,
                                           input offset_t word);
        return {tag, idx, word, 2'b00};
    endfunction

    task automatic abort_run;
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // holds the request until the cache takes it
    task automatic issue(input addr_t a, input strobe_t s, input word_t d);
        req_valid  = 1'b1;
        req_addr   = a;
        req_strobe = s;
        req_wdata  = d;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_done;
        @(posedge clk);
        #1;
        while (outstanding != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic access(input addr_t a, input strobe_t s, input word_t d);
        issue(a, s, d);
        wait_done();
    endtask

    // writes update the shadow in acceptance order
    always @(posedge clk) begin
        word_t cur;
        if (!resetn) begin
            if (data_ok && exp_read.size() != 0) begin
                void'(exp_read.pop_front());
                void'(exp_data.pop_front());
            end
            if (req_valid && addr_ok) begin
                cur = shadow_word(req_addr);
                if (req_strobe != '0) begin
                    shadow[req_addr] = merge_bytes(cur, req_wdata, req_strobe);
                end
                exp_read.push_back(req_strobe == '0);
                exp_data.push_back(cur);
            end
        end
        head_valid  <= exp_read.size() != 0;
        head_read   <= exp_read.size() != 0 && exp_read[0];
        head_data   <= (exp_data.size() != 0) ? exp_data[0] : '0;
        outstanding <= exp_read.size();
    end

    // bus monitor
    always @(posedge clk) begin
        word_t wb_expect;
        if (resetn) begin
            in_burst   <= 1'b0;
            burst_beat <= '0;
        end else if (creq_valid) begin
            if (!in_burst) begin
                burst_addr  <= creq_addr;
                burst_write <= creq_is_write;
                if (creq_is_write) begin
                    wb_count <= wb_count + 1;
                    wb_addr  <= creq_addr;
                end else begin
                    fetch_count <= fetch_count + 1;
                end
            end
            // written-back words carry every accepted write
            if (creq_is_write && cresp_ready) begin
                wb_expect = shadow_word(creq_addr + addr_t'({burst_beat, 2'b00}));
                assert (creq_wdata == wb_expect) else begin
                    $display("[ERROR] %0t creq_wdata: expected %h, got %h",
                             $time, wb_expect, creq_wdata);
                    abort_run();
                end
            end
            if (cresp_ready) begin
                burst_beat <= burst_beat + 1'b1;
            end
            in_burst <= !(cresp_ready && cresp_last);
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            abort_run();
        end
    end

    a_reset_state: assert property (@(posedge clk)
        cycle >= 1 && cycle <= reset_cycles + 1 |-> addr_ok && !data_ok && !creq_valid)
    else begin
        $display("[ERROR] %0t addr_ok/data_ok/creq_valid: expected 1/0/0, got %b/%b/%b",
                 $time, $sampled(addr_ok), $sampled(data_ok), $sampled(creq_valid));
        abort_run();
    end

    a_read_data: assert property (@(posedge clk) disable iff (resetn)
        data_ok && head_read |-> rdata == head_data)
    else begin
        $display("[ERROR] %0t rdata: expected %h, got %h",
                 $time, $sampled(head_data), $sampled(rdata));
        abort_run();
    end

    a_no_extra_data_ok: assert property (@(posedge clk) disable iff (resetn)
        data_ok |-> head_valid)
    else begin
        $display("data_ok came with no request outstanding");
        abort_run();
    end

    // a stalled port opens again only together with data_ok
    a_stall_until_data: assert property (@(posedge clk) disable iff (resetn)
        !addr_ok |=> !addr_ok || data_ok)
    else begin
        $display("addr_ok rose before the stalled request returned data_ok");
        abort_run();
    end

    a_replay_cycle: assert property (@(posedge clk) disable iff (resetn)
        creq_valid && !creq_is_write && cresp_ready && cresp_last |=> !addr_ok && !data_ok)
    else begin
        $display("no replay cycle after the last fetch beat");
        abort_run();
    end

    a_burst_hold: assert property (@(posedge clk) disable iff (resetn)
        creq_valid && in_burst |-> creq_addr == burst_addr && creq_is_write == burst_write)
    else begin
        $display("[ERROR] %0t creq_addr/creq_is_write: expected %h/%b, got %h/%b", $time,
                 $sampled(burst_addr), $sampled(burst_write),
                 $sampled(creq_addr), $sampled(creq_is_write));
        abort_run();
    end

    a_burst_unbroken: assert property (@(posedge clk) disable iff (resetn)
        in_burst |-> creq_valid)
    else begin
        $display("creq_valid dropped in the middle of a burst");
        abort_run();
    end

    a_line_aligned: assert property (@(posedge clk) disable iff (resetn)
        creq_valid |-> creq_addr[5:0] == '0)
    else begin
        $display("[ERROR] %0t creq_addr: expected %h, got %h", $time,
                 {$sampled(creq_addr[31:6]), 6'b0}, $sampled(creq_addr));
        abort_run();
    end

    initial begin
        int      i;
        int      fetch_before;
        int      wb_before;
        addr_t   a;
        strobe_t s;
        void'($urandom(32'h9f2d));
        resetn      = 1'b1;
        req_valid   = 1'b0;
        req_addr    = '0;
        req_strobe  = '0;
        req_wdata   = '0;
        fetch_count = 0;
        wb_count    = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        resetn = 1'b0;
        repeat (3) @(posedge clk);
        #1;

        // first reads miss, repeats hit
        for (i = 0; i < 8; i++) begin
            a = compose_addr(tag_t'(20'h10 + i), index_t'(i), offset_t'(i));
            access(a, '0, '0);
            access(a, '0, '0);
            access(compose_addr(tag_t'(20'h10 + i), index_t'(i), offset_t'(15 - i)), '0, '0);
        end
        for (i = 0; i < 16; i++) begin
            issue(compose_addr(tag_t'(20'h10), index_t'(0), offset_t'(i)), '0, '0);
        end
        wait_done();

        // write then read back, back to back on a resident line
        for (i = 0; i < 6; i++) begin
            a = compose_addr(tag_t'(20'h11), index_t'(1), offset_t'(i));
            issue(a, strobe_t'($urandom % 15 + 1), $urandom);
            issue(a, '0, '0);
        end
        wait_done();
        a = compose_addr(tag_t'(20'h200), index_t'(9), offset_t'(3));
        issue(a, 4'b0110, $urandom);
        issue(a, '0, '0);
        wait_done();

        // third dirty tag in set 20 pushes the first one out
        access(compose_addr(tag_t'(20'h301), index_t'(20), offset_t'(2)), 4'hf, $urandom);
        access(compose_addr(tag_t'(20'h302), index_t'(20), offset_t'(2)), 4'hf, $urandom);
        wb_before = wb_count;
        access(compose_addr(tag_t'(20'h303), index_t'(20), offset_t'(2)), 4'hf, $urandom);
        check_count("wb_count", wb_before + 1, wb_count);
        a = compose_addr(tag_t'(20'h301), index_t'(20), offset_t'(0));
        assert (wb_addr == a) else begin
            $display("[ERROR] %0t wb_addr: expected %h, got %h", $time, a, wb_addr);
            abort_run();
        end
        for (i = 0; i < 3; i++) begin
            access(compose_addr(tag_t'(20'h301 + i), index_t'(20), offset_t'(2)), '0, '0);
        end

        // A, B, A, then C must evict B
        access(compose_addr(tag_t'(20'h401), index_t'(33), offset_t'(5)), '0, '0);
        access(compose_addr(tag_t'(20'h402), index_t'(33), offset_t'(5)), '0, '0);
        access(compose_addr(tag_t'(20'h401), index_t'(33), offset_t'(6)), '0, '0);
        access(compose_addr(tag_t'(20'h403), index_t'(33), offset_t'(5)), '0, '0);
        fetch_before = fetch_count;
        wb_before    = wb_count;
        access(compose_addr(tag_t'(20'h401), index_t'(33), offset_t'(7)), '0, '0);
        check_count("fetch_count", fetch_before, fetch_count);
        check_count("wb_count", wb_before, wb_count);
        access(compose_addr(tag_t'(20'h402), index_t'(33), offset_t'(7)), '0, '0);
        check_count("fetch_count", fetch_before + 1, fetch_count);

        // random mix on two sets, issued without waiting
        for (i = 0; i < 40; i++) begin
            a = compose_addr(tag_t'(20'h500 + $urandom % 4), index_t'(40 + $urandom % 2),
                             offset_t'($urandom));
            if ($urandom % 2 != 0) begin
                s = strobe_t'($urandom % 15 + 1);
            end else begin
                s = '0;
            end
            issue(a, s, $urandom);
        end
        wait_done();

        $display("All tests passed");
        $finish;
    end

endmodule

/* src.f */
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_ifs.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_ram.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache_top.sv
bench/mem_model.sv
bench/tb_dcache.sv
